// File: source/conv_pkg.sv
package conv_pkg;

	// pixel, weight and bias format
	localparam int DATA_W = 16;
	localparam int FRAC_BITS = 8;

	// image and kernel geometry
	localparam int IMG_W = 6;
	localparam int IMG_H = 6;
	localparam int KERNEL = 3;
	localparam int TAPS = KERNEL * KERNEL;
	localparam int NUM_CH = 2;
	localparam int OUT_W = IMG_W - KERNEL + 1;

	// Q8.8 signed word
	typedef logic signed [DATA_W-1:0] sample_t;

	// nine full products need four guard bits
	typedef logic signed [2*DATA_W+3:0] acc_t;

	typedef logic [$clog2(IMG_W)-1:0] pos_t;

	// tap = row * KERNEL + col, row 0 is the oldest line
	typedef sample_t [TAPS-1:0] window_t;

	typedef sample_t [NUM_CH-1:0][TAPS-1:0] coef_t;
	typedef sample_t [NUM_CH-1:0] bias_t;

	// channel 0 in the low word
	typedef sample_t [NUM_CH-1:0] out_vec_t;

endpackage

// File: source/conv_window_if.sv
interface conv_window_if import conv_pkg::*; ();

	window_t win;
	logic win_valid;
	pos_t win_row;
	pos_t win_col;

	modport source
	(
		output win,
		output win_valid,
		output win_row,
		output win_col
	);

	modport sink
	(
		input win,
		input win_valid,
		input win_row,
		input win_col
	);

endinterface

// File: source/line_window.sv
module line_window import conv_pkg::*;
(
	input  logic clk,
	input  logic rst,
	input  logic pixel_valid,
	input  sample_t pixel_data,
	conv_window_if.source win_o
);

	pos_t row;
	pos_t col;

	// previous line and the one before it
	sample_t mid_line [IMG_W];
	sample_t old_line [IMG_W];

	// position of the incoming pixel, wraps at frame end
	always_ff @(posedge clk or posedge rst)
	begin
		if (rst)
		begin
			row <= '0;
			col <= '0;
		end
		else if (pixel_valid)
		begin
			if (col == pos_t'(IMG_W - 1))
			begin
				col <= '0;
				if (row == pos_t'(IMG_H - 1))
				begin
					row <= '0;
				end
				else
				begin
					row <= row + 1'b1;
				end
			end
			else
			begin
				col <= col + 1'b1;
			end
		end
	end

	always_ff @(posedge clk or posedge rst)
	begin
		if (rst)
		begin
			for (int i = 0; i < IMG_W; i++)
			begin
				mid_line[i] <= '0;
				old_line[i] <= '0;
			end
		end
		else if (pixel_valid)
		begin
			mid_line[0] <= pixel_data;
			old_line[0] <= mid_line[IMG_W-1];
			for (int i = 1; i < IMG_W; i++)
			begin
				mid_line[i] <= mid_line[i-1];
				old_line[i] <= old_line[i-1];
			end
		end
	end

	// window shifts left, new column enters on the right
	always_ff @(posedge clk or posedge rst)
	begin
		if (rst)
		begin
			win_o.win <= '0;
		end
		else if (pixel_valid)
		begin
			for (int r = 0; r < KERNEL; r++)
			begin
				for (int c = 0; c < KERNEL - 1; c++)
				begin
					win_o.win[r*KERNEL+c] <= win_o.win[r*KERNEL+c+1];
				end
			end
			win_o.win[KERNEL-1] <= old_line[IMG_W-1];
			win_o.win[2*KERNEL-1] <= mid_line[IMG_W-1];
			win_o.win[TAPS-1] <= pixel_data;
		end
	end

	// window complete once two lines and two columns are behind
	always_ff @(posedge clk or posedge rst)
	begin
		if (rst)
		begin
			win_o.win_valid <= 1'b0;
			win_o.win_row <= '0;
			win_o.win_col <= '0;
		end
		else
		begin
			win_o.win_valid <= pixel_valid && (row >= pos_t'(KERNEL - 1))
				&& (col >= pos_t'(KERNEL - 1));
			if (pixel_valid)
			begin
				win_o.win_row <= row - pos_t'(KERNEL - 1);
				win_o.win_col <= col - pos_t'(KERNEL - 1);
			end
		end
	end

endmodule

// File: source/coef_store.sv
module coef_store import conv_pkg::*;
(
	input  logic clk,
	input  logic rst,
	input  logic weight_valid,
	input  sample_t weight_data,
	input  logic bias_valid,
	input  sample_t bias_data,
	output coef_t weights,
	output bias_t biases
);

	// first weight loaded ends up at index 0, i.e. channel 0 tap 0
	sample_t [NUM_CH*TAPS-1:0] w_chain;
	logic [$clog2(NUM_CH*TAPS+1)-1:0] w_count;
	logic w_full;

	bias_t b_chain;
	logic [$clog2(NUM_CH+1)-1:0] b_count;
	logic b_full;

	assign w_full = (w_count == NUM_CH * TAPS);
	assign b_full = (b_count == NUM_CH);

	always_ff @(posedge clk or posedge rst)
	begin
		if (rst)
		begin
			w_chain <= '0;
			w_count <= '0;
		end
		else if (weight_valid && !w_full)
		begin
			w_chain <= {weight_data, w_chain[NUM_CH*TAPS-1:1]};
			w_count <= w_count + 1'b1;
		end
	end

	always_ff @(posedge clk or posedge rst)
	begin
		if (rst)
		begin
			b_chain <= '0;
			b_count <= '0;
		end
		else if (bias_valid && !b_full)
		begin
			b_chain <= {bias_data, b_chain[NUM_CH-1:1]};
			b_count <= b_count + 1'b1;
		end
	end

	// chain index is channel * TAPS + tap
	assign weights = w_chain;
	assign biases = b_chain;

endmodule

// File: source/conv_mac.sv
module conv_mac import conv_pkg::*;
(
	input  logic clk,
	input  logic rst,
	input  coef_t weights,
	input  bias_t biases,
	conv_window_if.sink win_i,
	output out_vec_t out_data
);

	logic signed [2*DATA_W-1:0] prod [NUM_CH][TAPS];
	logic prod_valid;
	acc_t tap_sum [NUM_CH];

	always_ff @(posedge clk or posedge rst)
	begin
		if (rst)
		begin
			prod_valid <= 1'b0;
		end
		else
		begin
			prod_valid <= win_i.win_valid;
		end
	end

	// stage 1, one product per tap and channel
	always_ff @(posedge clk)
	begin
		if (win_i.win_valid)
		begin
			for (int c = 0; c < NUM_CH; c++)
			begin
				for (int t = 0; t < TAPS; t++)
				begin
					prod[c][t] <= sample_t'(win_i.win[t]) * sample_t'(weights[c][t]);
				end
			end
		end
	end

	// adder tree at full precision
	always_comb
	begin
		for (int c = 0; c < NUM_CH; c++)
		begin
			tap_sum[c] = '0;
			for (int t = 0; t < TAPS; t++)
			begin
				tap_sum[c] = tap_sum[c] + acc_t'(prod[c][t]);
			end
		end
	end

	// stage 2, back to Q8.8 then bias, wraps on overflow
	always_ff @(posedge clk)
	begin
		if (prod_valid)
		begin
			for (int c = 0; c < NUM_CH; c++)
			begin
				out_data[c] <= sample_t'(tap_sum[c] >>> FRAC_BITS) + biases[c];
			end
		end
	end

endmodule

// File: source/conv_result.sv
module conv_result import conv_pkg::*;
(
	input  logic clk,
	input  logic rst,
	conv_window_if.sink win_i,
	output logic save_enable,
	output pos_t output_row,
	output pos_t output_col,
	output logic frame_done
);

	// follows the two MAC stages
	logic [1:0] vld_q;
	pos_t [1:0] row_q;
	pos_t [1:0] col_q;

	always_ff @(posedge clk or posedge rst)
	begin
		if (rst)
		begin
			vld_q <= '0;
			row_q <= '0;
			col_q <= '0;
		end
		else
		begin
			vld_q <= {vld_q[0], win_i.win_valid};
			row_q <= {row_q[0], win_i.win_row};
			col_q <= {col_q[0], win_i.win_col};
		end
	end

	assign save_enable = vld_q[1];
	assign output_row = row_q[1];
	assign output_col = col_q[1];

	// last output position of the frame
	assign frame_done = vld_q[1] && (row_q[1] == pos_t'(OUT_W - 1))
		&& (col_q[1] == pos_t'(OUT_W - 1));

endmodule

// File: source/conv_layer.sv
module conv_layer import conv_pkg::*;
(
	input  logic clk,
	input  logic rst,
	input  logic pixel_valid,
	input  sample_t pixel_data,
	input  logic weight_valid,
	input  sample_t weight_data,
	input  logic bias_valid,
	input  sample_t bias_data,
	output logic save_enable,
	output pos_t output_row,
	output pos_t output_col,
	output out_vec_t output_data,
	output logic frame_done
);

	coef_t weights;
	bias_t biases;

	conv_window_if win_if ();

	line_window line_window_i
	(
		.clk         (clk),
		.rst         (rst),
		.pixel_valid (pixel_valid),
		.pixel_data  (pixel_data),
		.win_o       (win_if.source)
	);

	coef_store coef_store_i
	(
		.clk          (clk),
		.rst          (rst),
		.weight_valid (weight_valid),
		.weight_data  (weight_data),
		.bias_valid   (bias_valid),
		.bias_data    (bias_data),
		.weights      (weights),
		.biases       (biases)
	);

	conv_mac conv_mac_i
	(
		.clk      (clk),
		.rst      (rst),
		.weights  (weights),
		.biases   (biases),
		.win_i    (win_if.sink),
		.out_data (output_data)
	);

	// position and strobes aligned with output_data
	conv_result conv_result_i
	(
		.clk         (clk),
		.rst         (rst),
		.win_i       (win_if.sink),
		.save_enable (save_enable),
		.output_row  (output_row),
		.output_col  (output_col),
		.frame_done  (frame_done)
	);

endmodule

// File: testbench/tb_conv_layer.sv
module tb_conv_layer import conv_pkg::*; ();

	timeunit 1ns;
	timeprecision 10ps;

	logic clk;
	logic rst;
	logic pixel_valid;
	sample_t pixel_data;
	logic weight_valid;
	sample_t weight_data;
	logic bias_valid;
	sample_t bias_data;
	logic save_enable;
	pos_t output_row;
	pos_t output_col;
	out_vec_t output_data;
	logic frame_done;

	integer seed = 32'hcfb365d6;
	int cycles = 0;
	int cycle_limit = 0;
	int mismatches = 0;
	int failures = 0;
	int frames_done = 0;
	int corner_edge = 0;

	sample_t weight_q [$];
	sample_t bias_q [$];
	sample_t pixel_q [$];
	// {row, col, ch0, ch1}, 16 bits each
	logic [63:0] file_exp [$];
	logic [63:0] pending [$];
	logic [63:0] exp_word;

	conv_layer dut_i (.*);

	initial
	begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	always @(posedge clk)
		cycles <= cycles + 1;

	task automatic check_value(input string name, input logic [15:0] expected,
		input logic [15:0] actual);
		if (actual !== expected)
		begin
			mismatches++;
			$display("MISMATCH time %0t %s expected %0h actual %0h", $time, name, expected, actual);
		end
	endtask

	task automatic read_vectors();
		int fd;
		int code;
		int row;
		int col;
		logic [7:0] tag;
		logic [15:0] value;
		logic [15:0] ch0;
		logic [15:0] ch1;
		logic [8*100-1:0] skip;
		fd = $fopen("testbench/conv_vectors.txt", "r");
		if (fd == 0)
		begin
			$display("could not open testbench/conv_vectors.txt");
			failures++;
			return;
		end
		while ($fscanf(fd, " %c", tag) == 1)
		begin
			case (tag)
				"#": code = $fgets(skip, fd);
				"w":
				begin
					repeat (TAPS)
					begin
						code = $fscanf(fd, "%h", value);
						weight_q.push_back(value);
					end
				end
				"b":
				begin
					repeat (NUM_CH)
					begin
						code = $fscanf(fd, "%h", value);
						bias_q.push_back(value);
					end
				end
				"p":
				begin
					repeat (IMG_W)
					begin
						code = $fscanf(fd, "%h", value);
						pixel_q.push_back(value);
					end
				end
				"e":
				begin
					code = $fscanf(fd, "%d %d %h %h", row, col, ch0, ch1);
					file_exp.push_back({16'(row), 16'(col), ch0, ch1});
				end
				default:
				begin
					$display("unknown line tag %c in the vector file", tag);
					failures++;
				end
			endcase
		end
		$fclose(fd);
		if (weight_q.size() != NUM_CH * TAPS || bias_q.size() != NUM_CH
			|| pixel_q.size() != 2 * IMG_W * IMG_H || file_exp.size() != 2 * OUT_W * OUT_W)
		begin
			$display("the vector file does not hold the expected number of entries");
			failures++;
		end
	endtask

	task automatic load_coefficients();
		for (int i = 0; i < weight_q.size(); i++)
		begin
			@(posedge clk);
			#10;
			weight_valid = 1'b1;
			weight_data = weight_q[i];
			bias_valid = (i < bias_q.size());
			if (i < bias_q.size())
				bias_data = bias_q[i];
		end
		@(posedge clk);
		#10;
		weight_valid = 1'b0;
		bias_valid = 1'b0;
	endtask

	// chains are full by now, none of this may land
	task automatic send_garbage();
		repeat (6)
		begin
			@(posedge clk);
			#10;
			weight_valid = 1'b1;
			bias_valid = 1'b1;
			weight_data = $random(seed);
			bias_data = $random(seed);
		end
		@(posedge clk);
		#10;
		weight_valid = 1'b0;
		bias_valid = 1'b0;
	endtask

	task automatic stream_frame(input int frame, input bit gapped);
		int gap;
		for (int k = 0; k < OUT_W * OUT_W; k++)
			pending.push_back(file_exp[frame*OUT_W*OUT_W + k]);
		for (int i = 0; i < IMG_W * IMG_H; i++)
		begin
			gap = gapped ? $unsigned($random(seed)) % 4 : 0;
			repeat (gap)
			begin
				@(posedge clk);
				#10;
				pixel_valid = 1'b0;
			end
			@(posedge clk);
			#10;
			pixel_valid = 1'b1;
			pixel_data = pixel_q[frame*IMG_W*IMG_H + i];
			// sampled on the next edge
			if (i == (KERNEL - 1) * IMG_W + KERNEL - 1)
				corner_edge = cycles + 1;
		end
		@(posedge clk);
		#10;
		pixel_valid = 1'b0;
	endtask

	task automatic wait_drain();
		int waited;
		waited = 0;
		while (pending.size() != 0 && waited < 50)
		begin
			@(posedge clk);
			waited++;
		end
	endtask

	always @(negedge clk)
	begin
		if (frame_done)
		begin
			frames_done++;
			if (!save_enable)
			begin
				$display("frame_done pulsed without save_enable at time %0t", $time);
				failures++;
			end
		end
		if (save_enable && pending.size() == 0)
		begin
			$display("unexpected output at row %0d col %0d, time %0t", output_row, output_col,
				$time);
			failures++;
		end
		else if (save_enable)
		begin
			exp_word = pending.pop_front();
			check_value("output_row", exp_word[63:48], output_row);
			check_value("output_col", exp_word[47:32], output_col);
			check_value("output_data ch0", exp_word[31:16], output_data[0]);
			check_value("output_data ch1", exp_word[15:0], output_data[1]);
			check_value("frame_done", exp_word[63:48] == OUT_W - 1
				&& exp_word[47:32] == OUT_W - 1, frame_done);
			if (exp_word[63:32] == 0)
				check_value("first output latency", 3, cycles - corner_edge + 1);
		end
	end

	initial
	begin
		@(negedge clk);
		while (cycle_limit == 0 || cycles < cycle_limit)
			@(negedge clk);
		$display("timeout after %0d cycles, the run did not complete", cycles);
		$display("errors: %0d mismatches, %0d other failures", mismatches, failures + 1);
		$display("SOME TESTS FAILED");
		$finish;
	end

	initial
	begin
		rst = 1'b1;
		pixel_valid = 1'b0;
		pixel_data = '0;
		weight_valid = 1'b0;
		weight_data = '0;
		bias_valid = 1'b0;
		bias_data = '0;
		read_vectors();
		// three frame runs
		cycle_limit = 4 * 3 * IMG_W * IMG_H + 200;
		repeat (5)
		begin
			@(negedge clk);
			check_value("save_enable", 0, save_enable);
			check_value("frame_done", 0, frame_done);
		end
		@(posedge clk);
		#10;
		rst = 1'b0;
		if (failures == 0)
		begin
			load_coefficients();
			stream_frame(0, 1'b0);
			wait_drain();
			send_garbage();
			stream_frame(0, 1'b1);
			stream_frame(1, 1'b1);
			wait_drain();
			repeat (5) @(posedge clk);
			check_value("frame_done count", 3, frames_done);
			if (pending.size() != 0)
			begin
				$display("%0d expected outputs never appeared", pending.size());
				failures++;
			end
		end
		$display("errors: %0d mismatches, %0d other failures", mismatches, failures);
		if (mismatches == 0 && failures == 0)
			$display("ALL TESTS PASSED");
		else
			$display("SOME TESTS FAILED");
		$finish;
	end

endmodule

// File: testbench/conv_vectors.txt
# w: nine weights of one channel, taps 0..8 / b: bias ch0 ch1 / p: six pixels of one row
# e: output row, output col (decimal), expected ch0, expected ch1 / data words hex Q8.8
w 0100 0200 0300 0400 0500 0600 0700 0800 0900
w FE00 0000 0000 0000 0180 0000 0000 0000 FFC0
b 0200 FF00
# frame 1 image
p 0100 0101 0102 0103 0104 0105
p 0110 0111 0112 0113 0114 0115
p 0120 0121 0122 0123 0124 0125
p 0130 0131 0132 0133 0134 0135
p 0140 0141 0142 0143 0144 0145
p 0150 0151 0152 0153 0154 0155
# frame 2 image
p FFC0 FFC8 FFD0 FFD8 FFE0 FFE8
p FFB0 FFB8 FFC0 FFC8 FFD0 FFD8
p FFA0 FFA8 FFB0 FFB8 FFC0 FFC8
p FF90 FF98 FFA0 FFA8 FFB0 FFB8
p FF80 FF88 FF90 FF98 FFA0 FFA8
p FF70 FF78 FF80 FF88 FF90 FF98
# frame 1 outputs
e 0 0 3323 FE51
e 0 1 3350 FE50
e 0 2 337D FE4F
e 0 3 33AA FE4E
e 1 0 35F3 FE45
e 1 1 3620 FE44
e 1 2 364D FE43
e 1 3 367A FE42
e 2 0 38C3 FE39
e 2 1 38F0 FE38
e 2 2 391D FE37
e 2 3 394A FE36
e 3 0 3B93 FE2D
e 3 1 3BC0 FE2C
e 3 2 3BED FE2B
e 3 3 3C1A FE2A
# frame 2 outputs
e 0 0 F468 FF28
e 0 1 F5D0 FF22
e 0 2 F738 FF1C
e 0 3 F8A0 FF16
e 1 0 F198 FF34
e 1 1 F300 FF2E
e 1 2 F468 FF28
e 1 3 F5D0 FF22
e 2 0 EEC8 FF40
e 2 1 F030 FF3A
e 2 2 F198 FF34
e 2 3 F300 FF2E
e 3 0 EBF8 FF4C
e 3 1 ED60 FF46
e 3 2 EEC8 FF40
e 3 3 F030 FF3A

// File: src.f
source/conv_pkg.sv
source/conv_window_if.sv
source/line_window.sv
source/coef_store.sv
source/conv_mac.sv
source/conv_result.sv
source/conv_layer.sv
testbench/tb_conv_layer.sv

// File: Bender.yml
package:
  name: conv_layer

sources:
  - source/conv_pkg.sv
  - source/conv_window_if.sv
  - source/line_window.sv
  - source/coef_store.sv
  - source/conv_mac.sv
  - source/conv_result.sv
  - source/conv_layer.sv
  - target: test
    files:
      - testbench/tb_conv_layer.sv
